// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_l1_data_cache
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/cache_data_way.sv ====
`timescale 1ns/1ps

module cache_data_way
	import l1_cache_pkg::*;
#(
	parameter int SET_BITS = 4
) (
	input  logic                   iCLOCK,
	input  logic                   wr_en,
	input  logic [SET_BITS-1:0]    wr_set,
	input  logic [CHUNK_SEL_W-1:0] wr_chunk,
	input  logic [CHUNK_W-1:0]     wr_data,
	input  logic                   rd_en,
	input  logic [SET_BITS-1:0]    rd_set,
	output logic [LINE_W-1:0]      line_out
);

	localparam int NUM_SETS = 1 << SET_BITS;

	logic [LINE_W-1:0] line_mem [NUM_SETS];

	// One 64-bit chunk per fill beat
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			line_mem[wr_set][wr_chunk*CHUNK_W +: CHUNK_W] <= wr_data;
		end
	end

	// Held between read enables, so a stalled response keeps its line
	always_ff @(posedge iCLOCK) begin
		if (rd_en) begin
			line_out <= line_mem[rd_set];
		end
	end

endmodule

// ==== hdl/cache_read_port.sv ====
`timescale 1ns/1ps

module cache_read_port
	import l1_cache_pkg::*;
(
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  logic                        flush,
	input  logic                        fill_valid,
	input  logic                        rd_valid,
	output logic                        rd_ready,
	input  cache_addr_t                 rd_addr,
	output logic                        rd_accept,
	input  logic                        lookup_hit,
	input  logic [$clog2(NUM_WAYS)-1:0] lookup_way,
	input  logic [LINE_W-1:0]           line_way0,
	input  logic [LINE_W-1:0]           line_way1,
	input  logic [LINE_W-1:0]           line_way2,
	input  logic [LINE_W-1:0]           line_way3,
	output logic                        resp_valid,
	input  logic                        resp_ready,
	output logic                        resp_hit,
	output logic [DATA_W-1:0]           resp_data
);

	logic [WORD_SEL_W-1:0] word_q;
	logic [LINE_W-1:0]     sel_line;

	// Fills win over reads; one response slot
	assign rd_ready  = !fill_valid && !flush && (!resp_valid || resp_ready);
	assign rd_accept = rd_valid && rd_ready;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_valid <= 1'b0;
		end else if (rd_accept) begin
			resp_valid <= 1'b1;
		end else if (resp_ready) begin
			resp_valid <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rd_accept) begin
			word_q <= rd_addr.rd.word_idx;
		end
	end

	always_comb begin
		case (lookup_way)
			2'd0:    sel_line = line_way0;
			2'd1:    sel_line = line_way1;
			2'd2:    sel_line = line_way2;
			default: sel_line = line_way3;
		endcase
	end

	assign resp_hit  = lookup_hit;
	assign resp_data = lookup_hit ? sel_line[word_q*DATA_W +: DATA_W] : '0;  // Zero on miss

	// Tag and data registers must both hold while the consumer stalls
	a_resp_stable: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		resp_valid && !resp_ready |=> $stable(resp_hit) && $stable(resp_data)
	);

endmodule

// ==== hdl/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array
	import l1_cache_pkg::*;
#(
	parameter int SET_BITS = 4
) (
	input  logic                        iCLOCK,
	input  logic                        inRESET,
	input  logic                        flush,
	input  logic                        fill_valid,
	output logic                        fill_ready,
	input  cache_addr_t                 fill_addr,
	input  logic                        rd_accept,
	input  cache_addr_t                 rd_addr,
	output logic                        lookup_hit,
	output logic [$clog2(NUM_WAYS)-1:0] lookup_way,
	output logic [NUM_WAYS-1:0]         way_wr_en
);

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_W    = ADDR_W - SET_BITS - OFFSET_W;
	localparam int WAY_W    = $clog2(NUM_WAYS);

	logic [TAG_W-1:0]    tag_mem    [NUM_WAYS][NUM_SETS];
	logic [STATUS_W-1:0] status_mem [NUM_WAYS][NUM_SETS];

	logic                               fill_fire;
	logic [SET_BITS-1:0]                fill_set;
	logic [TAG_W-1:0]                   fill_tag;
	logic [NUM_WAYS-1:0][STATUS_W-1:0]  fill_status;
	logic                               fill_hit;
	logic [WAY_W-1:0]                   fill_hit_way;
	logic [WAY_W-1:0]                   fill_way;
	logic [SET_BITS-1:0]                rd_set;
	logic [TAG_W-1:0]                   rd_tag;
	logic                               rd_hit;
	logic [WAY_W-1:0]                   rd_hit_way;

	// Preference: invalid, then status 1, then status 2, else last way
	function automatic logic [WAY_W-1:0] pick_victim(
		input logic [NUM_WAYS-1:0][STATUS_W-1:0] st
	);
		logic [WAY_W-1:0] way;
		logic             found;
		way   = WAY_W'(NUM_WAYS - 1);
		found = 1'b0;
		for (int lvl = 0; lvl < 3; lvl++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!found && st[w] == STATUS_W'(lvl)) begin
					way   = WAY_W'(w);
					found = 1'b1;
				end
			end
		end
		return way;
	endfunction

	assign fill_ready = !flush;
	assign fill_fire  = fill_valid && fill_ready;

	// Tag sits at the top of the address whatever the set count
	assign fill_set = fill_addr[OFFSET_W +: SET_BITS];
	assign fill_tag = fill_addr[ADDR_W-1 -: TAG_W];
	assign rd_set   = rd_addr[OFFSET_W +: SET_BITS];
	assign rd_tag   = rd_addr[ADDR_W-1 -: TAG_W];

	always_comb begin
		fill_hit     = 1'b0;
		fill_hit_way = '0;
		rd_hit       = 1'b0;
		rd_hit_way   = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			fill_status[w] = status_mem[w][fill_set];
			if (!fill_hit && status_mem[w][fill_set] != STATUS_INVALID &&
				tag_mem[w][fill_set] == fill_tag) begin
				fill_hit     = 1'b1;
				fill_hit_way = WAY_W'(w);
			end
			if (!rd_hit && status_mem[w][rd_set] != STATUS_INVALID &&
				tag_mem[w][rd_set] == rd_tag) begin
				rd_hit     = 1'b1;
				rd_hit_way = WAY_W'(w);
			end
		end
	end

	// Later chunks of a line hit the way the first chunk allocated
	assign fill_way  = fill_hit ? fill_hit_way : pick_victim(fill_status);
	assign way_wr_en = fill_fire ? (NUM_WAYS'(1) << fill_way) : '0;

	always_ff @(posedge iCLOCK) begin
		if (fill_fire && !fill_hit) begin
			tag_mem[fill_way][fill_set] <= fill_tag;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET || flush) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					status_mem[w][s] <= STATUS_INVALID;
				end
			end
		end else if (fill_fire) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (w == int'(fill_way)) begin
					status_mem[w][fill_set] <= STATUS_NEWEST;
				end else if (!fill_hit && fill_status[w] > STATUS_OLD) begin
					status_mem[w][fill_set] <= fill_status[w] - STATUS_W'(1); // Age, floor at 1
				end
			end
		end else if (rd_accept && rd_hit) begin
			status_mem[rd_hit_way][rd_set] <= STATUS_NEWEST;  // Refresh on read hit
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup_hit <= 1'b0;
			lookup_way <= '0;
		end else if (rd_accept) begin
			lookup_hit <= rd_hit;
			lookup_way <= rd_hit_way;
		end
	end

	// Read port keeps reads off the fill cycles
	a_no_read_during_fill: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) !(rd_accept && fill_fire)
	);

	// Back-to-back chunks of one line land in the same way
	a_fill_same_way: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		fill_fire && $past(fill_fire) && fill_set == $past(fill_set) &&
		fill_tag == $past(fill_tag) |-> way_wr_en == $past(way_wr_en)
	);

endmodule

// ==== hdl/l1_cache_pkg.sv ====
package l1_cache_pkg;

	// Bus and line geometry
	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int CHUNK_W     = 64;
	localparam int LINE_W      = 512;
	localparam int NUM_WAYS    = 4;   // Victim order assumes exactly four
	localparam int OFFSET_W    = 6;   // 64-byte line
	localparam int WORD_SEL_W  = 4;
	localparam int CHUNK_SEL_W = 3;

	// Address fields sized for the 16-set default
	localparam int DEFAULT_SET_BITS = 4;
	localparam int TAG_FIELD_W      = ADDR_W - DEFAULT_SET_BITS - OFFSET_W;

	// Per-way status, kept beside each tag
	localparam int STATUS_W = 2;
	localparam logic [STATUS_W-1:0] STATUS_INVALID = 2'd0;
	localparam logic [STATUS_W-1:0] STATUS_OLD     = 2'd1;
	localparam logic [STATUS_W-1:0] STATUS_NEWEST  = 2'd3;

	typedef struct packed {
		logic [TAG_FIELD_W-1:0]         tag;
		logic [DEFAULT_SET_BITS-1:0]    set_idx;
		logic [WORD_SEL_W-1:0]          word_idx;
		logic [OFFSET_W-WORD_SEL_W-1:0] byte_off;
	} rd_addr_view_t;

	typedef struct packed {
		logic [TAG_FIELD_W-1:0]          tag;
		logic [DEFAULT_SET_BITS-1:0]     set_idx;
		logic [CHUNK_SEL_W-1:0]          chunk_idx;
		logic [OFFSET_W-CHUNK_SEL_W-1:0] chunk_off;
	} fill_addr_view_t;

	// Same 32-bit address, word view for reads and chunk view for fills
	typedef union packed {
		rd_addr_view_t   rd;
		fill_addr_view_t fill;
	} cache_addr_t;

endpackage

// ==== hdl/l1_data_cache.sv ====
`timescale 1ns/1ps

module l1_data_cache
	import l1_cache_pkg::*;
#(
	parameter int SET_BITS = 4
) (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               flush,
	input  logic               rd_valid,
	output logic               rd_ready,
	input  cache_addr_t        rd_addr,
	output logic               resp_valid,
	input  logic               resp_ready,
	output logic               resp_hit,
	output logic [DATA_W-1:0]  resp_data,
	input  logic               fill_valid,
	output logic               fill_ready,
	input  cache_addr_t        fill_addr,
	input  logic [CHUNK_W-1:0] fill_data
);

	logic                        rd_accept;
	logic                        lookup_hit;
	logic [$clog2(NUM_WAYS)-1:0] lookup_way;
	logic [NUM_WAYS-1:0]         way_wr_en;
	logic [LINE_W-1:0]           line_out [NUM_WAYS];
	logic [SET_BITS-1:0]         fill_set;
	logic [CHUNK_SEL_W-1:0]      fill_chunk;
	logic [SET_BITS-1:0]         rd_set;

	// Set index follows SET_BITS, chunk comes from the fill view
	assign fill_set   = fill_addr[OFFSET_W +: SET_BITS];
	assign fill_chunk = fill_addr.fill.chunk_idx;
	assign rd_set     = rd_addr[OFFSET_W +: SET_BITS];

	cache_tag_array #(
		.SET_BITS (SET_BITS)
	) tag_array_inst (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.flush      (flush),
		.fill_valid (fill_valid),
		.fill_ready (fill_ready),
		.fill_addr  (fill_addr),
		.rd_accept  (rd_accept),
		.rd_addr    (rd_addr),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.way_wr_en  (way_wr_en)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_data_way #(
			.SET_BITS (SET_BITS)
		) data_way_inst (
			.iCLOCK   (iCLOCK),
			.wr_en    (way_wr_en[w]),
			.wr_set   (fill_set),
			.wr_chunk (fill_chunk),
			.wr_data  (fill_data),
			.rd_en    (rd_accept),  // All ways read, hit way picked later
			.rd_set   (rd_set),
			.line_out (line_out[w])
		);
	end

	cache_read_port read_port_inst (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.flush      (flush),
		.fill_valid (fill_valid),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.rd_addr    (rd_addr),
		.rd_accept  (rd_accept),
		.lookup_hit (lookup_hit),
		.lookup_way (lookup_way),
		.line_way0  (line_out[0]),
		.line_way1  (line_out[1]),
		.line_way2  (line_out[2]),
		.line_way3  (line_out[3]),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_hit   (resp_hit),
		.resp_data  (resp_data)
	);

endmodule

// ==== list.f ====
hdl/l1_cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_way.sv
hdl/cache_read_port.sv
hdl/l1_data_cache.sv
verif/tb_l1_data_cache.sv

// ==== verif/tb_l1_data_cache.sv ====
`timescale 1ns/1ps

module tb_l1_data_cache
	import l1_cache_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int TIMEOUT    = 100;  // Cycles per wait

	logic               iCLOCK;
	logic               inRESET;
	logic               flush;
	logic               rd_valid;
	logic               rd_ready;
	cache_addr_t        rd_addr;
	logic               resp_valid;
	logic               resp_ready;
	logic               resp_hit;
	logic [DATA_W-1:0]  resp_data;
	logic               fill_valid;
	logic               fill_ready;
	cache_addr_t        fill_addr;
	logic [CHUNK_W-1:0] fill_data;

	// Reference model, indexed [way][set]
	logic [LINE_W-1:0]   model_line   [NUM_WAYS][16];
	logic [21:0]         model_tag    [NUM_WAYS][16];
	logic [STATUS_W-1:0] model_status [NUM_WAYS][16];
	logic [ADDR_W-1:0]   filled_q [$];  // Base address of every filled line

	int errors;
	int timeouts;

	l1_data_cache #(
		.SET_BITS (4)
	) l1_data_cache_inst (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.flush      (flush),
		.rd_valid   (rd_valid),
		.rd_ready   (rd_ready),
		.rd_addr    (rd_addr),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_hit   (resp_hit),
		.resp_data  (resp_data),
		.fill_valid (fill_valid),
		.fill_ready (fill_ready),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data)
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	function automatic logic [31:0] make_addr(input logic [21:0] tag, input logic [3:0] set,
		input logic [3:0] word);
		return {tag, set, word, 2'b00};
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
	endtask

	function automatic int model_find(input logic [21:0] tag, input int set);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (model_status[w][set] != STATUS_INVALID && model_tag[w][set] == tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	// First invalid way, then oldest status 1, then status 2, else way 3
	function automatic int model_victim(input int set);
		for (int lvl = 0; lvl < 3; lvl++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (model_status[w][set] == STATUS_W'(lvl)) begin
					return w;
				end
			end
		end
		return NUM_WAYS - 1;
	endfunction

	task automatic model_fill(input logic [31:0] addr, input logic [63:0] data);
		int set;
		int chunk;
		int way;
		set   = int'(addr[9:6]);
		chunk = int'(addr[5:3]);
		way   = model_find(addr[31:10], set);
		if (way < 0) begin
			way = model_victim(set);
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (w != way && model_status[w][set] > STATUS_OLD) begin
					model_status[w][set] = model_status[w][set] - 2'd1;  // Aging step
				end
			end
			model_tag[way][set] = addr[31:10];
		end
		model_status[way][set] = STATUS_NEWEST;
		model_line[way][set][chunk*CHUNK_W +: CHUNK_W] = data;
	endtask

	task automatic model_read(input logic [31:0] addr, output logic hit, output logic [31:0] data);
		int set;
		int way;
		set = int'(addr[9:6]);
		way = model_find(addr[31:10], set);
		hit  = (way >= 0);
		data = '0;
		if (hit) begin
			data = model_line[way][set][int'(addr[5:2])*DATA_W +: DATA_W];
			model_status[way][set] = STATUS_NEWEST;  // Refresh on hit
		end
	endtask

	task automatic model_flush();
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int s = 0; s < 16; s++) begin
				model_status[w][s] = STATUS_INVALID;
			end
		end
	endtask

	task automatic fill_chunk(input logic [31:0] addr, input logic [63:0] data);
		int cnt;
		@(negedge iCLOCK);
		fill_valid = 1'b1;
		fill_addr  = addr;
		fill_data  = data;
		#1;
		cnt = 0;
		while (!fill_ready && cnt < TIMEOUT) begin
			@(negedge iCLOCK);
			#1;
			cnt++;
		end
		if (!fill_ready) begin
			report_timeout("fill chunk accept");
		end
		@(posedge iCLOCK);
		model_fill(addr, data);
	endtask

	task automatic fill_line(input logic [21:0] tag, input logic [3:0] set);
		logic [31:0] base;
		base = make_addr(tag, set, 4'd0);
		for (int c = 0; c < 8; c++) begin
			fill_chunk(base | 32'(c << 3), {$urandom, $urandom});
		end
		@(negedge iCLOCK);
		fill_valid = 1'b0;
		filled_q.push_back(base);
	endtask

	task automatic read_word(input logic [31:0] addr, input string what);
		logic        exp_hit;
		logic [31:0] exp_data;
		int          cnt;
		@(negedge iCLOCK);
		rd_valid = 1'b1;
		rd_addr  = addr;
		#1;
		cnt = 0;
		while (!rd_ready && cnt < TIMEOUT) begin
			@(negedge iCLOCK);
			#1;
			cnt++;
		end
		if (!rd_ready) begin
			report_timeout("read request accept");
		end
		@(posedge iCLOCK);
		model_read(addr, exp_hit, exp_data);
		@(negedge iCLOCK);
		rd_valid = 1'b0;
		cnt = 0;
		while (!resp_valid && cnt < TIMEOUT) begin
			@(negedge iCLOCK);
			cnt++;
		end
		if (!resp_valid) begin
			report_timeout("read response");
		end
		check_equal(resp_hit, exp_hit, {what, ", hit flag"});
		check_equal(resp_data, exp_data, {what, ", data"});
		#1;
		cnt = 0;
		while (!resp_ready && cnt < TIMEOUT) begin
			@(negedge iCLOCK);
			#1;
			cnt++;
		end
		if (!resp_ready) begin
			report_timeout("response ready");
		end
		@(posedge iCLOCK);  // Response taken here
	endtask

	// Holds resp_ready low and watches the held response
	task automatic hold_responses(input int cycles);
		logic        held_hit;
		logic [31:0] held_data;
		int          cnt;
		cnt = 0;
		@(negedge iCLOCK);
		while (!resp_valid && cnt < TIMEOUT) begin
			@(negedge iCLOCK);
			cnt++;
		end
		if (!resp_valid) begin
			report_timeout("stalled response");
		end
		held_hit  = resp_hit;
		held_data = resp_data;
		repeat (cycles) begin
			@(negedge iCLOCK);
			check_equal(resp_valid, 1'b1, "resp_valid under stall");
			check_equal(resp_hit, held_hit, "resp_hit under stall");
			check_equal(resp_data, held_data, "resp_data under stall");
			check_equal(rd_ready, 1'b0, "rd_ready under stall");
		end
		resp_ready = 1'b1;
	endtask

	task automatic test_after_reset();
		@(negedge iCLOCK);
		check_equal(resp_valid, 1'b0, "resp_valid after reset");
		check_equal(rd_ready, 1'b1, "rd_ready after reset");
		check_equal(fill_ready, 1'b1, "fill_ready after reset");
		for (int i = 0; i < 4; i++) begin
			read_word($urandom, "read before any fill");
		end
	endtask

	task automatic test_line_fill();
		logic [21:0] tag;
		tag = 22'($urandom);
		fill_line(tag, 4'd3);
		for (int w = 0; w < 16; w++) begin
			read_word(make_addr(tag, 4'd3, 4'(w)) | $urandom_range(3), "word of filled line");
		end
	endtask

	task automatic test_replacement();
		for (int i = 0; i < 5; i++) begin
			fill_line(22'h100 + 22'(i), 4'd7);
		end
		// Way 0 should be gone, the rest stay
		for (int i = 0; i < 5; i++) begin
			read_word(make_addr(22'h100 + 22'(i), 4'd7, 4'(i + 3)), "line after five fills");
		end
	endtask

	task automatic test_refresh();
		for (int i = 0; i < 4; i++) begin
			fill_line(22'h200 + 22'(i), 4'd9);
		end
		read_word(make_addr(22'h200, 4'd9, 4'd1), "refresh read");
		fill_line(22'h204, 4'd9);
		for (int i = 0; i < 5; i++) begin
			read_word(make_addr(22'h200 + 22'(i), 4'd9, 4'd2), "line after refresh");
		end
	endtask

	task automatic test_backpressure();
		fill_line(22'h3c1, 4'd11);
		@(negedge iCLOCK);
		resp_ready = 1'b0;
		fork
			begin
				read_word(make_addr(22'h3c1, 4'd11, 4'd2), "first read under stall");
				read_word(make_addr(22'h3c1, 4'd11, 4'd5), "read queued behind fill");
				read_word(make_addr(22'h3c1, 4'd11, 4'd9), "read after stall");
			end
			begin
				repeat (2) @(negedge iCLOCK);
				fill_line(22'h3c2, 4'd12);  // Other set, runs during the stall
			end
			hold_responses(6);
		join
		read_word(make_addr(22'h3c2, 4'd12, 4'd7), "line filled during stall");
	endtask

	task automatic test_flush();
		@(negedge iCLOCK);
		flush = 1'b1;
		#1;
		check_equal(fill_ready, 1'b0, "fill_ready during flush");
		check_equal(rd_ready, 1'b0, "rd_ready during flush");
		@(posedge iCLOCK);
		model_flush();
		@(negedge iCLOCK);
		flush = 1'b0;
		foreach (filled_q[i]) begin
			read_word(filled_q[i], "read after flush");
		end
		fill_line(22'h0bad1, 4'd3);
		read_word(make_addr(22'h0bad1, 4'd3, 4'd0), "refill after flush");
		read_word(make_addr(22'h0bad1, 4'd3, 4'd15), "refill after flush");
	endtask

	initial begin
		void'($urandom(32'h33e2_c7b9));
		errors     = 0;
		timeouts   = 0;
		iCLOCK     = 1'b0;
		inRESET    = 1'b0;
		flush      = 1'b0;
		rd_valid   = 1'b0;
		rd_addr    = '0;
		resp_ready = 1'b1;
		fill_valid = 1'b0;
		fill_addr  = '0;
		fill_data  = '0;
		model_flush();
		repeat (8) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		test_after_reset();
		test_line_fill();
		test_replacement();
		test_refresh();
		test_backpressure();
		test_flush();

		repeat (2) @(posedge iCLOCK);
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
